// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lsq
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/lsq_pkg.sv
`default_nettype none

package lsq_pkg;

  localparam int ADDR_W = 32;
  localparam int TAG_W  = 6;
  localparam int DATA_W = 64;

  typedef enum logic {
    OP_LOAD,
    OP_STORE
  } op_kind_e;

  typedef enum logic [1:0] {
    SZ_1,
    SZ_2,
    SZ_4,
    SZ_8
  } acc_size_e;

  // one issued memory op, data unused for loads
  typedef struct packed {
    op_kind_e          kind;
    acc_size_e         size;
    logic [TAG_W-1:0]  tag;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } mem_op_t;

  typedef struct packed {
    logic [ADDR_W-4:0] word;
    logic [7:0]        bgn_ben;
    logic [7:0]        end_ben;
  } byte_span_t;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [ADDR_W-1:0] addr;
    logic              ldconfl;
  } ld_entry_t;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [ADDR_W-1:0] addr;
    acc_size_e         size;
    logic [DATA_W-1:0] data;
  } st_entry_t;

  typedef struct packed {
    op_kind_e          kind;
    logic [TAG_W-1:0]  tag;
    logic [ADDR_W-1:0] addr;
    logic              ldconfl;
  } ret_info_t;

  typedef struct packed {
    logic              en;
    logic [ADDR_W-4:0] word;
    logic [7:0]        bgn_ben;
    logic [7:0]        end_ben;
    logic [127:0]      data128;
  } st_req_t;

  // bytes touched in the addressed word and the one after it
  function automatic byte_span_t byte_span(input logic [ADDR_W-1:0] addr,
                                           input acc_size_e size);
    byte_span_t  span;
    logic [7:0]  base;
    logic [15:0] mask;
    case (size)
      SZ_1:    base = 8'h01;
      SZ_2:    base = 8'h03;
      SZ_4:    base = 8'h0f;
      default: base = 8'hff;
    endcase
    mask = {8'h00, base} << addr[2:0];
    span.word = addr[ADDR_W-1:3];
    span.bgn_ben = mask[7:0];
    span.end_ben = mask[15:8];
    return span;
  endfunction

endpackage

`default_nettype wire

// File: hdl/lsq_retire.sv
`default_nettype none
`timescale 1ns/10ps

module lsq_retire import lsq_pkg::*; #(
  parameter int LDQ_DEPTH = 8,
  parameter int STQ_DEPTH = 8
) (
  input  wire       clk,
  input  wire       rst,
  input  wire       except,
  input  wire       op_en,
  input  wire       mem_op_t op,
  input  wire       retire_req,
  output logic      retire_ack,
  output ret_info_t ret,
  input  wire       ld_entry_t ld_head,
  input  wire       st_entry_t st_head,
  output logic      ld_pop,
  output logic      st_pop,
  output logic      wp_load,
  input  wire       wp_free
);

  localparam int ORD_DEPTH = LDQ_DEPTH + STQ_DEPTH;
  localparam int PTR_W = $clog2(ORD_DEPTH);
  localparam int CNT_W = $clog2(ORD_DEPTH + 1);

  op_kind_e         ord_mem [ORD_DEPTH];
  logic [PTR_W-1:0] ord_wr;
  logic [PTR_W-1:0] ord_rd;
  logic [CNT_W-1:0] ord_cnt;
  op_kind_e         oldest;
  logic             do_ack;

  assign oldest = ord_mem[ord_rd];

  // a store also needs the write port to be empty
  assign do_ack = retire_req && !retire_ack && (ord_cnt != '0) &&
                  ((oldest == OP_LOAD) || wp_free);
  assign ld_pop = do_ack && (oldest == OP_LOAD);
  assign st_pop = do_ack && (oldest == OP_STORE);
  assign wp_load = st_pop;

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_ack <= 1'b0;
    end else if (do_ack) begin
      retire_ack <= 1'b1;
    end else if (!retire_req) begin
      retire_ack <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (do_ack) begin
      ret.kind <= oldest;
      ret.tag <= (oldest == OP_LOAD) ? ld_head.tag : st_head.tag;
      ret.addr <= (oldest == OP_LOAD) ? ld_head.addr : st_head.addr;
      ret.ldconfl <= (oldest == OP_LOAD) && ld_head.ldconfl;
    end
  end

  // program order of kinds
  always_ff @(posedge clk) begin
    if (rst || except) begin
      ord_wr <= '0;
      ord_rd <= '0;
      ord_cnt <= '0;
    end else begin
      if (op_en) begin
        ord_wr <= (ord_wr == PTR_W'(ORD_DEPTH - 1)) ? '0 : ord_wr + 1'b1;
      end
      if (do_ack) begin
        ord_rd <= (ord_rd == PTR_W'(ORD_DEPTH - 1)) ? '0 : ord_rd + 1'b1;
      end
      case ({op_en, do_ack})
        2'b10:   ord_cnt <= ord_cnt + 1'b1;
        2'b01:   ord_cnt <= ord_cnt - 1'b1;
        default: ord_cnt <= ord_cnt;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (op_en) begin
      ord_mem[ord_wr] <= op.kind;
    end
  end

endmodule

`default_nettype wire

// File: hdl/lsq_top.sv
`default_nettype none
`timescale 1ns/10ps

module lsq_top import lsq_pkg::*; #(
  parameter int LDQ_DEPTH = 8,
  parameter int STQ_DEPTH = 8
) (
  input  wire       clk,
  input  wire       rst,
  input  wire       except,
  input  wire       op_en,
  input  wire       mem_op_t op,
  output logic      ld_full,
  output logic      st_full,
  input  wire       retire_req,
  output logic      retire_ack,
  output ret_info_t ret,
  input  wire       st_stall,
  output st_req_t   st_req
);

  logic      ld_confl;
  logic      ld_pop;
  logic      st_pop;
  logic      wp_load;
  logic      wp_free;
  ld_entry_t ld_head;
  st_entry_t st_head;

  ldq #(.LDQ_DEPTH(LDQ_DEPTH)) u_ldq (
    .clk      (clk),
    .rst      (rst),
    .except   (except),
    .op_en    (op_en),
    .op       (op),
    .ld_confl (ld_confl),
    .ld_pop   (ld_pop),
    .ld_head  (ld_head),
    .ld_full  (ld_full)
  );

  stq #(.STQ_DEPTH(STQ_DEPTH)) u_stq (
    .clk      (clk),
    .rst      (rst),
    .except   (except),
    .op_en    (op_en),
    .op       (op),
    .ld_confl (ld_confl),
    .st_pop   (st_pop),
    .st_head  (st_head),
    .st_full  (st_full)
  );

  lsq_retire #(.LDQ_DEPTH(LDQ_DEPTH), .STQ_DEPTH(STQ_DEPTH)) u_lsq_retire (
    .clk        (clk),
    .rst        (rst),
    .except     (except),
    .op_en      (op_en),
    .op         (op),
    .retire_req (retire_req),
    .retire_ack (retire_ack),
    .ret        (ret),
    .ld_head    (ld_head),
    .st_head    (st_head),
    .ld_pop     (ld_pop),
    .st_pop     (st_pop),
    .wp_load    (wp_load),
    .wp_free    (wp_free)
  );

  st_write_port u_st_write_port (
    .clk      (clk),
    .rst      (rst),
    .wp_load  (wp_load),
    .st_head  (st_head),
    .wp_free  (wp_free),
    .st_stall (st_stall),
    .st_req   (st_req)
  );

endmodule

`default_nettype wire

// File: ldq/ldq.sv
`default_nettype none
`timescale 1ns/10ps

module ldq import lsq_pkg::*; #(
  parameter int LDQ_DEPTH = 8
) (
  input  wire       clk,
  input  wire       rst,
  input  wire       except,
  input  wire       op_en,
  input  wire       mem_op_t op,
  input  wire       ld_confl,
  input  wire       ld_pop,
  output ld_entry_t ld_head,
  output logic      ld_full
);

  localparam int PTR_W = (LDQ_DEPTH > 1) ? $clog2(LDQ_DEPTH) : 1;
  localparam int CNT_W = $clog2(LDQ_DEPTH + 1);

  ld_entry_t        mem [LDQ_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign ld_full = (count == CNT_W'(LDQ_DEPTH));
  assign push = op_en && (op.kind == OP_LOAD) && !ld_full;
  assign pop = ld_pop && (count != '0);
  assign ld_head = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst || except) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        if (wr_ptr == PTR_W'(LDQ_DEPTH - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (pop) begin
        if (rd_ptr == PTR_W'(LDQ_DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // conflict bit from stq is captured with the load
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= '{tag: op.tag, addr: op.addr, ldconfl: ld_confl};
    end
  end

endmodule

`default_nettype wire

// File: src.f
common/lsq_pkg.sv
ldq/ldq.sv
stq/stq.sv
stq/st_write_port.sv
hdl/lsq_retire.sv
hdl/lsq_top.sv
tb/tb_lsq.sv

// File: stq/st_write_port.sv
`default_nettype none
`timescale 1ns/10ps

module st_write_port import lsq_pkg::*; (
  input  wire       clk,
  input  wire       rst,
  input  wire       wp_load,
  input  wire       st_entry_t st_head,
  output logic      wp_free,
  input  wire       st_stall,
  output st_req_t   st_req
);

  st_entry_t    ent;
  logic         held;
  byte_span_t   span;
  logic [127:0] data_wide;

  assign wp_free = !held;

  // stays held until a cycle without stall
  always_ff @(posedge clk) begin
    if (rst) begin
      held <= 1'b0;
    end else begin
      held <= wp_load || (held && st_stall);
    end
  end

  always_ff @(posedge clk) begin
    if (wp_load) begin
      ent <= st_head;
    end
  end

  assign span = byte_span(ent.addr, ent.size);
  assign data_wide = 128'(ent.data);

  always_comb begin
    st_req.en = held && !st_stall;
    st_req.word = span.word;
    st_req.bgn_ben = span.bgn_ben;
    st_req.end_ben = span.end_ben;
    // byte lane shift by the low address bits
    st_req.data128 = data_wide << {ent.addr[2:0], 3'b000};
  end

endmodule

`default_nettype wire

// File: stq/stq.sv
`default_nettype none
`timescale 1ns/10ps

module stq import lsq_pkg::*; #(
  parameter int STQ_DEPTH = 8
) (
  input  wire       clk,
  input  wire       rst,
  input  wire       except,
  input  wire       op_en,
  input  wire       mem_op_t op,
  output logic      ld_confl,
  input  wire       st_pop,
  output st_entry_t st_head,
  output logic      st_full
);

  localparam int PTR_W = (STQ_DEPTH > 1) ? $clog2(STQ_DEPTH) : 1;

  st_entry_t        mem [STQ_DEPTH];
  logic [STQ_DEPTH-1:0] valid;
  logic [STQ_DEPTH-1:0] hit;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             push;
  logic             pop;
  logic             is_load;
  byte_span_t       ld_span;

  // any shared byte in either word of either access
  function automatic logic spans_overlap(input byte_span_t ld, input byte_span_t st);
    logic [ADDR_W-4:0] ld_next;
    logic [ADDR_W-4:0] st_next;
    ld_next = ld.word + 1'b1;
    st_next = st.word + 1'b1;
    return ((ld.word == st.word) && |(ld.bgn_ben & st.bgn_ben)) ||
           ((ld.word == st_next) && |(ld.bgn_ben & st.end_ben)) ||
           ((ld_next == st.word) && |(ld.end_ben & st.bgn_ben));
  endfunction

  // slot under the write pointer still valid means the ring is full
  assign st_full = valid[wr_ptr];
  assign push = op_en && (op.kind == OP_STORE) && !st_full;
  assign pop = st_pop && valid[rd_ptr];
  assign st_head = mem[rd_ptr];

  assign is_load = op_en && (op.kind == OP_LOAD);
  assign ld_span = byte_span(op.addr, op.size);

  always_comb begin
    hit = '0;
    for (int i = 0; i < STQ_DEPTH; i++) begin
      hit[i] = valid[i] && spans_overlap(ld_span, byte_span(mem[i].addr, mem[i].size));
    end
  end

  assign ld_confl = is_load && (|hit);

  always_ff @(posedge clk) begin
    if (rst || except) begin
      valid <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        valid[wr_ptr] <= 1'b1;
        if (wr_ptr == PTR_W'(STQ_DEPTH - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (pop) begin
        valid[rd_ptr] <= 1'b0;
        if (rd_ptr == PTR_W'(STQ_DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= '{tag: op.tag, addr: op.addr, size: op.size, data: op.data};
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_lsq.sv
`default_nettype none
`timescale 1ns/10ps

module tb_lsq import lsq_pkg::*; ();

  localparam int LDQ_DEPTH  = 8;
  localparam int STQ_DEPTH  = 8;
  localparam int CLK_PERIOD = 100;
  localparam int TIMEOUT    = 50;
  localparam int NO_ACK_WAIT = 20;

  logic      clk;
  logic      rst;
  logic      except;
  logic      op_en;
  mem_op_t   op;
  logic      ld_full;
  logic      st_full;
  logic      retire_req;
  logic      retire_ack;
  ret_info_t ret;
  logic      st_stall;
  st_req_t   st_req;

  string       test_name;
  int          errors;
  int          errors_at_start;
  int          tests_run;
  int          tests_failed;

  lsq_top #(.LDQ_DEPTH(LDQ_DEPTH), .STQ_DEPTH(STQ_DEPTH)) u_lsq_top (
    .clk        (clk),
    .rst        (rst),
    .except     (except),
    .op_en      (op_en),
    .op         (op),
    .ld_full    (ld_full),
    .st_full    (st_full),
    .retire_req (retire_req),
    .retire_ack (retire_ack),
    .ret        (ret),
    .st_stall   (st_stall),
    .st_req     (st_req)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input string what, input logic [127:0] exp_v,
                             input logic [127:0] act_v);
    assert (act_v === exp_v) else begin
      $display("** Error %s: %s expected %0h actual %0h", test_name, what, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic check_true(input string what, input logic cond);
    assert (cond === 1'b1) else begin
      $display("%s: %s", test_name, what);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    errors_at_start = errors;
    tests_run++;
  endtask

  task automatic end_test();
    if (errors == errors_at_start) begin
      $display("%s: ok", test_name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  // called just after a falling edge, returns after the next one
  task automatic issue_op(input op_kind_e kind, input acc_size_e size,
                          input logic [TAG_W-1:0] tag, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data);
    op_en = 1'b1;
    op = '{kind: kind, size: size, tag: tag, addr: addr, data: data};
    @(negedge clk);
    op_en = 1'b0;
    op = '0;
  endtask

  task automatic request_retire(input int limit, output logic acked);
    int n;
    n = 0;
    retire_req = 1'b1;
    while (!retire_ack && n < limit) begin
      @(negedge clk);
      n++;
    end
    acked = retire_ack;
  endtask

  task automatic release_retire();
    int n;
    n = 0;
    retire_req = 1'b0;
    while (retire_ack && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    check_true("retire ack stayed high after the request dropped", !retire_ack);
  endtask

  task automatic retire_op(output ret_info_t r);
    logic acked;
    request_retire(TIMEOUT, acked);
    check_true("no retire ack within the timeout", acked);
    r = ret;
    release_retire();
  endtask

  task automatic expect_load(input logic [TAG_W-1:0] tag, input logic [ADDR_W-1:0] addr,
                             input logic confl);
    ret_info_t r;
    retire_op(r);
    check_value("kind", 128'(OP_LOAD), 128'(r.kind));
    check_value("tag", 128'(tag), 128'(r.tag));
    check_value("addr", 128'(addr), 128'(r.addr));
    check_value("ldconfl", 128'(confl), 128'(r.ldconfl));
  endtask

  task automatic expect_store(input logic [TAG_W-1:0] tag, input logic [ADDR_W-1:0] addr);
    ret_info_t r;
    retire_op(r);
    check_value("kind", 128'(OP_STORE), 128'(r.kind));
    check_value("tag", 128'(tag), 128'(r.tag));
    check_value("addr", 128'(addr), 128'(r.addr));
    check_value("ldconfl", 128'(0), 128'(r.ldconfl));
  endtask

  task automatic load_order_test();
    logic [ADDR_W-1:0] addrs [4];
    begin_test("load_order");
    for (int i = 0; i < 4; i++) begin
      addrs[i] = $urandom;
      issue_op(OP_LOAD, SZ_4, TAG_W'(i + 1), addrs[i], '0);
    end
    for (int i = 0; i < 4; i++) begin
      expect_load(TAG_W'(i + 1), addrs[i], 1'b0);
    end
    end_test();
  endtask

  task automatic conflict_test();
    begin_test("conflict");
    issue_op(OP_STORE, SZ_4, 6'd8, 32'h106, 64'hdead_beef);
    issue_op(OP_LOAD, SZ_1, 6'd9, 32'h108, '0);
    issue_op(OP_LOAD, SZ_1, 6'd10, 32'h10a, '0);
    issue_op(OP_LOAD, SZ_8, 6'd11, 32'h0f8, '0);
    expect_store(6'd8, 32'h106);
    // the store has already left the queue
    issue_op(OP_LOAD, SZ_1, 6'd12, 32'h108, '0);
    expect_load(6'd9, 32'h108, 1'b1);
    expect_load(6'd10, 32'h10a, 1'b0);
    expect_load(6'd11, 32'h0f8, 1'b0);
    expect_load(6'd12, 32'h108, 1'b0);
    end_test();
  endtask

  task automatic store_write_test();
    logic [DATA_W-1:0] data;
    logic [127:0]      exp_data;
    int                n;
    begin_test("store_write");
    data = 64'h1122_3344_5566_7788;
    exp_data = {64'h0, data} << 24;
    st_stall = 1'b1;
    issue_op(OP_STORE, SZ_8, 6'd20, 32'h203, data);
    expect_store(6'd20, 32'h203);
    for (int i = 0; i < 10; i++) begin
      check_value("en under stall", 128'(0), 128'(st_req.en));
      check_value("word", 128'(29'h40), 128'(st_req.word));
      check_value("bgn_ben", 128'(8'hf8), 128'(st_req.bgn_ben));
      check_value("end_ben", 128'(8'h07), 128'(st_req.end_ben));
      check_value("data128", exp_data, st_req.data128);
      @(negedge clk);
    end
    st_stall = 1'b0;
    #(CLK_PERIOD / 4);
    n = 0;
    while (!st_req.en && n < TIMEOUT) begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
      n++;
    end
    check_true("store request never enabled after the stall dropped", st_req.en);
    @(negedge clk);
    check_value("en after accept", 128'(0), 128'(st_req.en));
    end_test();
  endtask

  task automatic backpressure_test();
    logic      acked;
    ret_info_t r;
    begin_test("backpressure_full");
    st_stall = 1'b1;
    issue_op(OP_STORE, SZ_4, 6'd30, 32'h300, 64'h1);
    issue_op(OP_STORE, SZ_4, 6'd31, 32'h308, 64'h2);
    expect_store(6'd30, 32'h300);
    request_retire(NO_ACK_WAIT, acked);
    check_true("second store acked while the write port was held", !acked);
    st_stall = 1'b0;
    request_retire(TIMEOUT, acked);
    check_true("second store never acked after the stall dropped", acked);
    r = ret;
    release_retire();
    check_value("kind", 128'(OP_STORE), 128'(r.kind));
    check_value("tag", 128'(6'd31), 128'(r.tag));
    check_value("addr", 128'(32'h308), 128'(r.addr));
    check_value("ldconfl", 128'(0), 128'(r.ldconfl));
    check_value("ld_full before fill", 128'(0), 128'(ld_full));
    for (int i = 0; i < LDQ_DEPTH; i++) begin
      issue_op(OP_LOAD, SZ_2, TAG_W'(32 + i), ADDR_W'(32'h400 + 2 * i), '0);
    end
    check_value("ld_full after fill", 128'(1), 128'(ld_full));
    expect_load(TAG_W'(32), 32'h400, 1'b0);
    check_value("ld_full after retire", 128'(0), 128'(ld_full));
    for (int i = 1; i < LDQ_DEPTH; i++) begin
      expect_load(TAG_W'(32 + i), ADDR_W'(32'h400 + 2 * i), 1'b0);
    end
    end_test();
  endtask

  task automatic flush_test();
    logic acked;
    begin_test("flush");
    for (int i = 0; i < LDQ_DEPTH; i++) begin
      issue_op(OP_LOAD, SZ_1, TAG_W'(i), ADDR_W'(32'h600 + i), '0);
    end
    for (int i = 0; i < STQ_DEPTH; i++) begin
      issue_op(OP_STORE, SZ_8, TAG_W'(16 + i), ADDR_W'(32'h700 + 8 * i), 64'(i));
    end
    check_value("ld_full before flush", 128'(1), 128'(ld_full));
    check_value("st_full before flush", 128'(1), 128'(st_full));
    except = 1'b1;
    @(negedge clk);
    except = 1'b0;
    check_value("ld_full after flush", 128'(0), 128'(ld_full));
    check_value("st_full after flush", 128'(0), 128'(st_full));
    request_retire(NO_ACK_WAIT, acked);
    check_true("retire acked with nothing left after the flush", !acked);
    release_retire();
    issue_op(OP_LOAD, SZ_4, 6'h2a, 32'h500, '0);
    expect_load(6'h2a, 32'h500, 1'b0);
    end_test();
  endtask

  initial begin
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    rst = 1'b1;
    except = 1'b0;
    op_en = 1'b0;
    op = '0;
    retire_req = 1'b0;
    st_stall = 1'b0;
    void'($urandom(32'he59f));
    repeat (2) @(negedge clk);
    rst = 1'b0;
    check_value("retire_ack after reset", 128'(0), 128'(retire_ack));
    check_value("st_req.en after reset", 128'(0), 128'(st_req.en));
    check_value("ld_full after reset", 128'(0), 128'(ld_full));
    check_value("st_full after reset", 128'(0), 128'(st_full));
    load_order_test();
    conflict_test();
    store_write_test();
    backpressure_test();
    flush_test();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
